// ==== source/vec_engine_pkg.sv ====
package vec_engine_pkg;

    // Widths of the datapath and of the two address spaces.
    localparam int WORD_W    = 32;
    localparam int COEF_W    = 16;
    localparam int ELEM_AW   = 5;
    localparam int STREAM_AW = 4;

    localparam int NUM_ELEMS  = 32;
    // src_buf read plus the two vec_alu stages.
    localparam int PIPE_DEPTH = 3;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [2*WORD_W-1:0]  dword_t;
    typedef logic [ELEM_AW-1:0]   elem_addr_t;
    typedef logic [STREAM_AW-1:0] stream_addr_t;
    typedef logic [COEF_W-1:0]    coef_t;

    // One result on its way into dst_buf.
    typedef struct packed {
        logic       out_period;
        elem_addr_t out_addr;
        word_t      result;
    } wb_t;

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        DRAIN
    } ctrl_state_t;

endpackage

// ==== source/src_buf.sv ====
`timescale 1ns/100ps

module src_buf
    import vec_engine_pkg::*;
(
    input  logic         clk,
    input  logic         in_v,
    input  stream_addr_t in_a,
    input  dword_t       in_d,
    input  logic         rd_v,
    input  elem_addr_t   rd_addr,
    output word_t        rd_data
);

    // Even elements live in one bank, odd elements in the other.
    word_t bank_even [16];
    word_t bank_odd  [16];

    // A host word fills one entry of each bank.
    always_ff @(posedge clk) begin
        if (in_v) begin
            bank_even[in_a] <= in_d[WORD_W-1:0];
            bank_odd[in_a]  <= in_d[2*WORD_W-1:WORD_W];
        end
    end

    // Registered read, element address bit 0 picks the bank.
    always_ff @(posedge clk) begin
        if (rd_v) begin
            if (rd_addr[0]) begin
                rd_data <= bank_odd[rd_addr[4:1]];
            end
            else begin
                rd_data <= bank_even[rd_addr[4:1]];
            end
        end
    end

endmodule

// ==== source/seq_ctrl.sv ====
`timescale 1ns/100ps

module seq_ctrl
    import vec_engine_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    output logic       busy,
    output logic       done,
    output logic       rd_v,
    output elem_addr_t rd_addr
);

    ctrl_state_t state;
    logic [1:0]  drain_cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            busy      <= 1'b0;
            done      <= 1'b0;
            rd_v      <= 1'b0;
            rd_addr   <= '0;
            drain_cnt <= '0;
        end
        else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    // start is only looked at here, so it is ignored while busy.
                    if (start) begin
                        state   <= ISSUE;
                        busy    <= 1'b1;
                        rd_v    <= 1'b1;
                        rd_addr <= '0;
                    end
                end
                ISSUE: begin
                    if (rd_addr == elem_addr_t'(NUM_ELEMS - 1)) begin
                        state     <= DRAIN;
                        rd_v      <= 1'b0;
                        drain_cnt <= '0;
                    end
                    else begin
                        rd_addr <= rd_addr + 1'b1;
                    end
                end
                DRAIN: begin
                    // The done register itself covers the last pipeline cycle,
                    // so done lines up with the write of element 31.
                    if (drain_cnt == 2'(PIPE_DEPTH - 2)) begin
                        state <= IDLE;
                        busy  <= 1'b0;
                        done  <= 1'b1;
                    end
                    else begin
                        drain_cnt <= drain_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// ==== source/vec_alu.sv ====
`timescale 1ns/100ps

module vec_alu
    import vec_engine_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       issue_v,
    input  elem_addr_t issue_addr,
    input  word_t      operand,
    input  coef_t      coef,
    input  word_t      bias,
    output wb_t        wb
);

    logic       s1_v;
    elem_addr_t s1_addr;
    word_t      s1_prod;

    // Stage one. Only the low 32 bits of the product reach the result.
    always_ff @(posedge clk) begin
        if (reset) begin
            s1_v <= 1'b0;
        end
        else begin
            s1_v <= issue_v;
        end
    end

    always_ff @(posedge clk) begin
        s1_addr <= issue_addr;
        s1_prod <= operand * word_t'(coef);
    end

    // Stage two adds bias and wraps at 32 bits.
    always_ff @(posedge clk) begin
        if (reset) begin
            wb.out_period <= 1'b0;
        end
        else begin
            wb.out_period <= s1_v;
        end
    end

    always_ff @(posedge clk) begin
        wb.out_addr <= s1_addr;
        wb.result   <= s1_prod + bias;
    end

endmodule

// ==== source/dst_buf.sv ====
`timescale 1ns/100ps

module dst_buf
    import vec_engine_pkg::*;
(
    input  logic         clk,
    input  logic         stream_v,
    input  stream_addr_t stream_a,
    input  logic         out_period,
    input  elem_addr_t   out_addr,
    input  word_t        result,
    output dword_t       stream_d
);

    // Four banks of 8 results. The half comes from element address bit 4
    // and the parity from bit 0.
    for (genvar h = 0; h < 2; h++) begin : g_half
        for (genvar p = 0; p < 2; p++) begin : g_par
            word_t mem [8];
            word_t rd_q;
            logic  wr_hit;
            logic  rd_hit;

            assign wr_hit = out_period && (out_addr[4] == 1'(h)) && (out_addr[0] == 1'(p));
            assign rd_hit = stream_v && (stream_a[3] == 1'(h));

            // A write wins over a stream read of the same half.
            always_ff @(posedge clk) begin
                if (wr_hit) begin
                    mem[out_addr[3:1]] <= result;
                end
                else if (rd_hit) begin
                    rd_q <= mem[stream_a[2:0]];
                end
            end
        end
    end

    // Odd element goes in the high half of the stream word.
    assign stream_d = stream_a[3] ? {g_half[1].g_par[1].rd_q, g_half[1].g_par[0].rd_q}
                                  : {g_half[0].g_par[1].rd_q, g_half[0].g_par[0].rd_q};

endmodule

// ==== source/vec_engine.sv ====
`timescale 1ns/100ps

module vec_engine
    import vec_engine_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         in_v,
    input  stream_addr_t in_a,
    input  dword_t       in_d,
    input  logic         start,
    input  coef_t        coef,
    input  word_t        bias,
    output logic         busy,
    output logic         done,
    input  logic         stream_v,
    input  stream_addr_t stream_a,
    output dword_t       stream_d
);

    logic       rd_v;
    elem_addr_t rd_addr;
    word_t      rd_data;
    logic       issue_v;
    elem_addr_t issue_addr;
    wb_t        wb;

    src_buf i_src_buf (
        .clk     (clk),
        .in_v    (in_v),
        .in_a    (in_a),
        .in_d    (in_d),
        .rd_v    (rd_v),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    seq_ctrl i_seq_ctrl (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .busy    (busy),
        .done    (done),
        .rd_v    (rd_v),
        .rd_addr (rd_addr)
    );

    // Match the read latency of src_buf so address and data meet at the ALU.
    always_ff @(posedge clk) begin
        if (reset) begin
            issue_v <= 1'b0;
        end
        else begin
            issue_v <= rd_v;
        end
    end

    always_ff @(posedge clk) begin
        issue_addr <= rd_addr;
    end

    vec_alu i_vec_alu (
        .clk        (clk),
        .reset      (reset),
        .issue_v    (issue_v),
        .issue_addr (issue_addr),
        .operand    (rd_data),
        .coef       (coef),
        .bias       (bias),
        .wb         (wb)
    );

    dst_buf i_dst_buf (
        .clk        (clk),
        .stream_v   (stream_v),
        .stream_a   (stream_a),
        .out_period (wb.out_period),
        .out_addr   (wb.out_addr),
        .result     (wb.result),
        .stream_d   (stream_d)
    );

endmodule

// ==== tests/vec_engine_chk.sv ====
`timescale 1ns/100ps

module vec_engine_chk
    import vec_engine_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic in_v,
    input logic stream_v,
    input logic start,
    input logic busy,
    input logic done
);

    // Failure counts, read by the testbench at the end of the run.
    int unsigned host_fails    = 0;
    int unsigned pulse_fails   = 0;
    int unsigned latency_fails = 0;

    // Both buffers belong to the engine while a job runs.
    host_idle_a: assert property (@(posedge clk) disable iff (reset)
        busy |-> !in_v && !stream_v)
    else begin
        $error("host touched a buffer while busy");
        host_fails++;
    end

    done_pulse_a: assert property (@(posedge clk) disable iff (reset)
        done |=> !done)
    else begin
        $error("done stayed high for more than one cycle");
        pulse_fails++;
    end

    // A start taken in idle ends with done one pipeline drain after the last issue.
    done_latency_a: assert property (@(posedge clk) disable iff (reset)
        start && !busy |-> ##(NUM_ELEMS + PIPE_DEPTH) done)
    else begin
        $error("done did not follow start at the expected cycle");
        latency_fails++;
    end

endmodule

bind vec_engine vec_engine_chk i_vec_engine_chk (
    .clk      (clk),
    .reset    (reset),
    .in_v     (in_v),
    .stream_v (stream_v),
    .start    (start),
    .busy     (busy),
    .done     (done)
);

// ==== tests/vec_engine_tb.sv ====
`timescale 1ns/100ps

module vec_engine_tb
    import vec_engine_pkg::*;
();

    localparam int CLK_PERIOD = 8;
    localparam int NUM_WORDS  = NUM_ELEMS / 2;
    localparam int JOB_CYCLES = NUM_ELEMS + PIPE_DEPTH;
    // Ten jobs of load, compute and read back, doubled.
    localparam int WATCHDOG_CYCLES = 2 * 10 * (16 + 40 + 32);

    logic         clk;
    logic         reset;
    logic         in_v;
    stream_addr_t in_a;
    dword_t       in_d;
    logic         start;
    coef_t        coef;
    word_t        bias;
    logic         busy;
    logic         done;
    logic         stream_v;
    stream_addr_t stream_a;
    dword_t       stream_d;

    logic [31:0] lfsr;
    word_t       model [NUM_ELEMS];
    int          checks;
    int          errors;
    int          test_num;
    int          test_errors;

    vec_engine i_vec_engine (
        .clk      (clk),
        .reset    (reset),
        .in_v     (in_v),
        .in_a     (in_a),
        .in_d     (in_d),
        .start    (start),
        .coef     (coef),
        .bias     (bias),
        .busy     (busy),
        .done     (done),
        .stream_v (stream_v),
        .stream_a (stream_a),
        .stream_d (stream_d)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run is stuck.", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // One LFSR step for every bit taken.
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    // Full-width product, then keep the low word.
    function automatic word_t expect_result(input word_t elem, input coef_t c, input word_t b);
        logic [63:0] full;
        full = {32'b0, elem} * {48'b0, c} + {32'b0, b};
        return full[31:0];
    endfunction

    // Element number in the low bits, parity marker in the top byte.
    function automatic dword_t mapping_pattern(input int a);
        return {32'hb0b0_0000 | (2 * a + 1), 32'ha0a0_0000 | (2 * a)};
    endfunction

    task automatic load_word(input stream_addr_t a, input dword_t d);
        @(posedge clk);
        in_v <= 1'b1;
        in_a <= a;
        in_d <= d;
        model[2 * int'(a)]     = d[31:0];
        model[2 * int'(a) + 1] = d[63:32];
    endtask

    task automatic end_load();
        @(posedge clk);
        in_v <= 1'b0;
    endtask

    task automatic load_random();
        for (int a = 0; a < NUM_WORDS; a++) begin
            load_word(stream_addr_t'(a), rand_bits(64));
        end
        end_load();
    endtask

    // Busy is checked on every cycle until done. With extra_start a second
    // start arrives in the middle of the job.
    task automatic run_job(input coef_t c, input word_t b, input bit extra_start);
        int n;
        bit seen;
        @(posedge clk);
        start <= 1'b1;
        coef  <= c;
        bias  <= b;
        @(posedge clk);
        start <= 1'b0;
        n = 0;
        seen = 1'b0;
        while (!seen && n < 3 * JOB_CYCLES) begin
            @(posedge clk);
            n++;
            if (extra_start) begin
                start <= (n == 10);
            end
            if (done) begin
                seen = 1'b1;
            end
            else begin
                checks++;
                assert (busy === 1'b1) else begin
                    $display("ERR busy cycle %0d exp=%h got=%h", n, 1'b1, busy);
                    errors++;
                end
            end
        end
        checks++;
        assert (seen) else begin
            $display("No done within %0d cycles after start.", 3 * JOB_CYCLES);
            errors++;
        end
        if (seen) begin
            checks++;
            assert (n == JOB_CYCLES) else begin
                $display("ERR done_cycles exp=%h got=%h", JOB_CYCLES, n);
                errors++;
            end
        end
    endtask

    task automatic check_word(input stream_addr_t a);
        dword_t exp;
        dword_t got;
        exp = {expect_result(model[2 * int'(a) + 1], coef, bias),
               expect_result(model[2 * int'(a)], coef, bias)};
        @(posedge clk);
        stream_v <= 1'b1;
        stream_a <= a;
        @(posedge clk);
        stream_v <= 1'b0;
        @(posedge clk);
        got = stream_d;
        checks++;
        assert (got === exp) else begin
            $display("ERR stream_d addr=%h exp=%h got=%h", a, exp, got);
            errors++;
        end
    endtask

    task automatic check_all();
        for (int a = 0; a < NUM_WORDS; a++) begin
            check_word(stream_addr_t'(a));
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %0d %-10s %s (%0d errors)", test_num, name,
                 (errors == test_errors) ? "ok" : "bad", errors - test_errors);
        test_num++;
        test_errors = errors;
    endtask

    initial begin
        int order [NUM_WORDS];
        int j;
        int tmp;
        int chk_fails;
        lfsr = 32'hdcc8_4a0a;
        checks = 0;
        errors = 0;
        test_num = 1;
        test_errors = 0;
        reset    <= 1'b1;
        in_v     <= 1'b0;
        in_a     <= '0;
        in_d     <= '0;
        start    <= 1'b0;
        coef     <= '0;
        bias     <= '0;
        stream_v <= 1'b0;
        stream_a <= '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // Unit coefficient and zero bias pass the elements through.
        load_random();
        run_job(16'd1, 32'd0, 1'b0);
        check_all();
        finish_test("basic");

        // The first job forces the largest coef and bias so the sum wraps.
        for (int i = 0; i < 5; i++) begin
            load_random();
            run_job((i == 0) ? 16'hffff : coef_t'(rand_bits(16)),
                    (i == 0) ? 32'hffff_ffff : word_t'(rand_bits(32)), 1'b0);
            check_all();
        end
        finish_test("arith");

        // Words at both ends of each half.
        load_word(4'd0, mapping_pattern(0));
        load_word(4'd7, mapping_pattern(7));
        load_word(4'd8, mapping_pattern(8));
        load_word(4'd15, mapping_pattern(15));
        end_load();
        run_job(16'd1, 32'd0, 1'b0);
        check_word(4'd0);
        check_word(4'd7);
        check_word(4'd8);
        check_word(4'd15);
        finish_test("mapping");

        // Reset arrives in the middle of a running job.
        load_random();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        repeat (10) @(posedge clk);
        checks++;
        assert (busy === 1'b1) else begin
            $display("ERR busy exp=%h got=%h", 1'b1, busy);
            errors++;
        end
        reset <= 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        checks++;
        assert (busy === 1'b0 && done === 1'b0) else begin
            $display("ERR busy_done exp=%h got=%h", 2'b00, {busy, done});
            errors++;
        end
        load_random();
        run_job(coef_t'(rand_bits(16)), word_t'(rand_bits(32)), 1'b1);
        // The start sent while busy must not produce a second done.
        repeat (JOB_CYCLES + 5) begin
            @(posedge clk);
            checks++;
            assert (done === 1'b0 && busy === 1'b0) else begin
                $display("ERR busy_done exp=%h got=%h", 2'b00, {busy, done});
                errors++;
            end
        end
        check_all();
        load_random();
        run_job(coef_t'(rand_bits(16)), word_t'(rand_bits(32)), 1'b0);
        check_all();
        finish_test("control");

        load_random();
        run_job(coef_t'(rand_bits(16)), word_t'(rand_bits(32)), 1'b0);
        for (int i = 0; i < NUM_WORDS; i++) begin
            order[i] = i;
        end
        for (int i = NUM_WORDS - 1; i > 0; i--) begin
            j = int'(rand_bits(5)) % (i + 1);
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < NUM_WORDS; i++) begin
            check_word(stream_addr_t'(order[i]));
        end
        check_word(stream_addr_t'(order[0]));
        check_word(stream_addr_t'(order[0]));
        finish_test("order");

        chk_fails = int'(i_vec_engine.i_vec_engine_chk.host_fails)
                  + int'(i_vec_engine.i_vec_engine_chk.pulse_fails)
                  + int'(i_vec_engine.i_vec_engine_chk.latency_fails);
        errors += chk_fails;
        $display("checks %0d, assertion failures %0d, errors %0d", checks, chk_fails, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end
        else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== vec_engine.f ====
source/vec_engine_pkg.sv
source/src_buf.sv
source/seq_ctrl.sv
source/vec_alu.sv
source/dst_buf.sv
source/vec_engine.sv
tests/vec_engine_chk.sv
tests/vec_engine_tb.sv

// ==== Makefile ====
TOP := vec_engine_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -f vec_engine.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
